//--- design/reset_pkg.sv
`default_nettype none

package reset_pkg;

    //////////////////////////////////////////////////
    // reset stretching

    // about 100 ms at 80 MHz
    localparam int unsigned RESET_HOLD_DEFAULT = 8_000_000;

    // hold counter width
    localparam int unsigned RESET_CNT_W = 32;

    //////////////////////////////////////////////////
    // status led selection

    // width of the crossed reset configuration byte
    localparam int unsigned RESET_CONF_W = 8;

    // led shows transmitter not ready
    localparam logic [RESET_CONF_W-1:0] LED_MODE_ADV = 8'd0;

    // led follows the console reset
    localparam logic [RESET_CONF_W-1:0] LED_MODE_DC = 8'd2;

    // any other value: led follows the optional reset

endpackage

`default_nettype wire

//--- design/adv_pkg.sv
`default_nettype none

package adv_pkg;

    //////////////////////////////////////////////////
    // transmitter configuration frames

    // bytes per frame, first byte is the top of the word
    localparam int unsigned ADV_FRAME_BYTES = 4;

    // FIFO data width
    localparam int unsigned ADV_BYTE_W = 8;

    // assembled configuration word
    localparam int unsigned ADV_CFG_W = ADV_FRAME_BYTES * ADV_BYTE_W;

    // byte index within a frame
    localparam int unsigned ADV_IDX_W = $clog2(ADV_FRAME_BYTES);

    //////////////////////////////////////////////////
    // transmitter power-up delay

    // 400 ms at 80 MHz
    localparam int unsigned ADV_STARTUP_DEFAULT = 32_000_000;

    // startup counter width
    localparam int unsigned ADV_STARTUP_CNT_W = 32;

endpackage

`default_nettype wire

//--- design/reset_stretch.sv
`timescale 1ns/100ps
`default_nettype none

module reset_stretch
    import reset_pkg::*;
#(
    parameter int unsigned hold_cycles = RESET_HOLD_DEFAULT
) (
    input  logic control_clock,
    input  logic reset_dc_out,
    input  logic req,
    output logic nreset
);

    logic [RESET_CNT_W-1:0] cnt;
    logic                   done;

    // counter parks at the hold value
    assign done = (cnt == RESET_CNT_W'(hold_cycles));

    // a request beats the reset, so a copy whose request is
    // reset_dc_out itself starts out held low
    always_ff @(posedge control_clock) begin
        if (req) begin
            cnt    <= '0;
            nreset <= 1'b0;
        end else if (reset_dc_out) begin
            // released, counter already done
            cnt    <= RESET_CNT_W'(hold_cycles);
            nreset <= 1'b1;
        end else begin
            if (!done) begin
                cnt <= cnt + 1'b1;
            end
            nreset <= done;
        end
    end

endmodule

`default_nettype wire

//--- design/reset_manager.sv
`timescale 1ns/100ps
`default_nettype none

module reset_manager
    import reset_pkg::*;
#(
    parameter int unsigned hold_cycles = RESET_HOLD_DEFAULT
) (
    input  logic                    control_clock,
    input  logic                    reset_dc_out,
    input  logic                    reset_opt_out,
    input  logic [RESET_CONF_W-1:0] reset_conf_out,
    input  logic                    adv7513_ready,
    output logic                    dc_nreset,
    output logic                    opt_nreset,
    output logic                    status_led_nreset
);

    //////////////////////////////////////////////////
    // stretched reset levels

    // console reset, the subsystem reset is the request
    reset_stretch #(
        .hold_cycles(hold_cycles)
    ) dc_stretch_i (
        .control_clock(control_clock),
        .reset_dc_out (reset_dc_out),
        .req          (reset_dc_out),
        .nreset       (dc_nreset)
    );

    // optional port reset
    reset_stretch #(
        .hold_cycles(hold_cycles)
    ) opt_stretch_i (
        .control_clock(control_clock),
        .reset_dc_out (reset_dc_out),
        .req          (reset_opt_out),
        .nreset       (opt_nreset)
    );

    //////////////////////////////////////////////////
    // status led

    // source picked by the config byte, one cycle late
    always_ff @(posedge control_clock) begin
        case (reset_conf_out)
            LED_MODE_DC: begin
                status_led_nreset <= dc_nreset;
            end
            LED_MODE_ADV: begin
                // lit until the transmitter reports ready
                status_led_nreset <= ~adv7513_ready;
            end
            default: begin
                status_led_nreset <= opt_nreset;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/lock_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module lock_monitor (
    input  logic control_clock,
    input  logic reset_dc_out,
    input  logic pll54_locked,
    input  logic pll_hdmi_locked,
    input  logic fullcycle,
    output logic pll54_lockloss,
    output logic pll_hdmi_lockloss,
    output logic output_ready
);

    // bit 0 pll54, bit 1 pll_hdmi, bit 2 fullcycle
    logic [2:0] meta_q;
    logic [2:0] sync_q;

    // lock bits only
    logic [1:0] lock_prev;
    logic [1:0] lockloss_q;

    //////////////////////////////////////////////////
    // synchronizers and falling edge detect

    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            meta_q     <= '0;
            sync_q     <= '0;
            lock_prev  <= '0;
            lockloss_q <= '0;
        end else begin
            meta_q     <= {fullcycle, pll_hdmi_locked, pll54_locked};
            sync_q     <= meta_q;
            lock_prev  <= sync_q[1:0];
            // one pulse per lost lock
            lockloss_q <= lock_prev & ~sync_q[1:0];
        end
    end

    assign pll54_lockloss    = lockloss_q[0];
    assign pll_hdmi_lockloss = lockloss_q[1];

    // hdmi pll locked and a full frame seen
    assign output_ready = sync_q[1] & sync_q[2];

endmodule

`default_nettype wire

//--- design/startup_delay.sv
`timescale 1ns/100ps
`default_nettype none

module startup_delay
    import adv_pkg::*;
#(
    // at least 1
    parameter int unsigned startup_cycles = ADV_STARTUP_DEFAULT
) (
    input  logic control_clock,
    input  logic reset_dc_out,
    output logic adv_start
);

    logic [ADV_STARTUP_CNT_W-1:0] cnt;

    // holds the transmitter driver off after power-up
    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            cnt       <= '0;
            adv_start <= 1'b0;
        end else if (!adv_start) begin
            cnt       <= cnt + 1'b1;
            // terminal count, then stop
            adv_start <= (cnt == ADV_STARTUP_CNT_W'(startup_cycles - 1));
        end
    end

endmodule

`default_nettype wire

//--- design/adv_config_reader.sv
`timescale 1ns/100ps
`default_nettype none

module adv_config_reader
    import adv_pkg::*;
(
    input  logic                  control_clock,
    input  logic                  reset_dc_out,
    input  logic                  fifo_rdempty,
    input  logic [ADV_BYTE_W-1:0] fifo_q,
    output logic                  fifo_rdreq,
    output logic [ADV_CFG_W-1:0]  adv_config,
    output logic                  cfg_update
);

    logic                 rd_enable;
    logic                 pend;
    logic [ADV_IDX_W-1:0] byte_idx;
    logic                 frame_done;
    logic [ADV_CFG_W-1:0] shift_q;

    //////////////////////////////////////////////////
    // FIFO pop side

    // pop whenever a byte is there, no back-pressure
    assign fifo_rdreq = rd_enable & ~fifo_rdempty;

    always_ff @(posedge control_clock) begin
        if (reset_dc_out) begin
            rd_enable  <= 1'b0;
            pend       <= 1'b0;
            byte_idx   <= '0;
            frame_done <= 1'b0;
            cfg_update <= 1'b0;
            adv_config <= '0;
        end else begin
            rd_enable  <= 1'b1;
            // fifo_q is valid the cycle after a pop
            pend       <= fifo_rdreq;
            frame_done <= 1'b0;
            cfg_update <= frame_done;
            if (frame_done) begin
                adv_config <= shift_q;
            end
            if (pend) begin
                if (byte_idx == ADV_IDX_W'(ADV_FRAME_BYTES - 1)) begin
                    byte_idx   <= '0;
                    frame_done <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // frame assembly

    // first byte ends up in the top byte
    always_ff @(posedge control_clock) begin
        if (pend) begin
            shift_q <= {shift_q[ADV_CFG_W-ADV_BYTE_W-1:0], fifo_q};
        end
    end

endmodule

`default_nettype wire

//--- design/control_domain_top.sv
`timescale 1ns/100ps
`default_nettype none

module control_domain_top
    import reset_pkg::*, adv_pkg::*;
#(
    parameter int unsigned hold_cycles    = RESET_HOLD_DEFAULT,
    parameter int unsigned startup_cycles = ADV_STARTUP_DEFAULT
) (
    input  logic                    control_clock,
    input  logic                    reset_dc_out,
    input  logic                    reset_opt_out,
    input  logic [RESET_CONF_W-1:0] reset_conf_out,
    input  logic                    pll54_locked,
    input  logic                    pll_hdmi_locked,
    input  logic                    fullcycle,
    input  logic                    adv7513_ready,
    input  logic                    fifo_rdempty,
    input  logic [ADV_BYTE_W-1:0]   fifo_q,
    output logic                    fifo_rdreq,
    output logic                    dc_nreset,
    output logic                    opt_nreset,
    output logic                    status_led_nreset,
    output logic                    pll54_lockloss,
    output logic                    pll_hdmi_lockloss,
    output logic                    output_ready,
    output logic                    adv_start,
    output logic [ADV_CFG_W-1:0]    adv_config,
    output logic                    cfg_update
);

    //////////////////////////////////////////////////
    // resets and status led

    reset_manager #(
        .hold_cycles(hold_cycles)
    ) reset_manager_i (
        .control_clock    (control_clock),
        .reset_dc_out     (reset_dc_out),
        .reset_opt_out    (reset_opt_out),
        .reset_conf_out   (reset_conf_out),
        .adv7513_ready    (adv7513_ready),
        .dc_nreset        (dc_nreset),
        .opt_nreset       (opt_nreset),
        .status_led_nreset(status_led_nreset)
    );

    //////////////////////////////////////////////////
    // pll lock and output readiness

    lock_monitor lock_monitor_i (
        .control_clock    (control_clock),
        .reset_dc_out     (reset_dc_out),
        .pll54_locked     (pll54_locked),
        .pll_hdmi_locked  (pll_hdmi_locked),
        .fullcycle        (fullcycle),
        .pll54_lockloss   (pll54_lockloss),
        .pll_hdmi_lockloss(pll_hdmi_lockloss),
        .output_ready     (output_ready)
    );

    //////////////////////////////////////////////////
    // transmitter startup and configuration

    startup_delay #(
        .startup_cycles(startup_cycles)
    ) startup_delay_i (
        .control_clock(control_clock),
        .reset_dc_out (reset_dc_out),
        .adv_start    (adv_start)
    );

    adv_config_reader adv_config_reader_i (
        .control_clock(control_clock),
        .reset_dc_out (reset_dc_out),
        .fifo_rdempty (fifo_rdempty),
        .fifo_q       (fifo_q),
        .fifo_rdreq   (fifo_rdreq),
        .adv_config   (adv_config),
        .cfg_update   (cfg_update)
    );

endmodule

`default_nettype wire

//--- dv/control_domain_props.sv
`timescale 1ns/100ps
`default_nettype none

module control_domain_props (
    input logic control_clock,
    input logic reset_dc_out,
    input logic req,
    input logic nreset,
    input logic fifo_rdempty,
    input logic fifo_rdreq,
    input logic cfg_update
);

    // failures so far, summed at the end of the run
    int unsigned fail_count = 0;

    // stretched reset held low under a request
    req_holds_nreset: assert property (@(posedge control_clock) req |=> !nreset)
    else begin
        $error("nreset not low after a cycle with req high");
        fail_count++;
    end

    no_empty_pop: assert property (@(posedge control_clock) !(fifo_rdreq && fifo_rdempty))
    else begin
        $error("fifo_rdreq high while fifo_rdempty high");
        fail_count++;
    end

    single_update: assert property (
        @(posedge control_clock) disable iff (reset_dc_out) cfg_update |=> !cfg_update
    ) else begin
        $error("cfg_update high for more than one cycle");
        fail_count++;
    end

endmodule

bind reset_stretch control_domain_props props_i (
    .control_clock, .reset_dc_out, .req, .nreset,
    .fifo_rdempty(1'b0), .fifo_rdreq(1'b0), .cfg_update(1'b0)
);

bind adv_config_reader control_domain_props props_i (
    .control_clock, .reset_dc_out, .req(1'b0), .nreset(1'b0),
    .fifo_rdempty, .fifo_rdreq, .cfg_update
);

`default_nettype wire

//--- dv/control_domain_tb.sv
`timescale 1ns/100ps
`default_nettype none

module control_domain_tb
    import reset_pkg::*, adv_pkg::*;
();

    localparam int unsigned hold_len     = 40;
    localparam int unsigned startup_len  = 100;
    localparam int unsigned mixed_len    = 600;
    localparam int unsigned frame_total  = 32;
    localparam int unsigned frame_budget = 1000;
    localparam int unsigned cycle_limit  = 2 + mixed_len + frame_budget + 2 + startup_len + 200;

    logic                    control_clock = 1'b1;
    logic                    reset_dc_out, reset_opt_out, adv7513_ready, fifo_rdempty;
    logic                    pll54_locked, pll_hdmi_locked, fullcycle;
    logic [RESET_CONF_W-1:0] reset_conf_out;
    logic [ADV_BYTE_W-1:0]   fifo_q;
    logic                    fifo_rdreq, dc_nreset, opt_nreset, status_led_nreset;
    logic                    pll54_lockloss, pll_hdmi_lockloss, output_ready, adv_start;
    logic                    cfg_update;
    logic [ADV_CFG_W-1:0]    adv_config;

    // reference model state
    int unsigned           dc_since = 0, opt_since = 0, start_cnt = 0, nbytes = 0;
    int unsigned           frames_seen = 0, pushed = 0, cycle_cnt = 0;
    int unsigned           rst_left = 0, opt_left = 0;
    logic                  dc_exp, opt_exp, led_exp, ready_exp, start_exp, upd_exp;
    logic                  rden_exp = 1'b0, pend_m = 1'b0, done_m = 1'b0;
    logic                  rdreq_prev, push_on = 1'b0;
    logic [1:0]            loss_exp;
    logic [11:0]           lk_hist = '0;
    logic [ADV_BYTE_W-1:0] pend_byte, fifo_mem[$];
    logic [ADV_CFG_W-1:0]  word_m, cfg_exp;

    control_domain_top #(
        .hold_cycles   (hold_len),
        .startup_cycles(startup_len)
    ) dut_i (.*);

    always #10 control_clock = ~control_clock;

    always @(posedge control_clock) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    task automatic fail_now(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    task automatic check_pulse(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("%s pulse is %b, expected %b", name, got, exp));
    endtask

    task automatic check_config(input logic [ADV_CFG_W-1:0] got,
                                input logic [ADV_CFG_W-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("adv_config is %h, expected %h", got, exp));
    endtask

    function automatic int unsigned property_failures();
        return dut_i.reset_manager_i.dc_stretch_i.props_i.fail_count
             + dut_i.reset_manager_i.opt_stretch_i.props_i.fail_count
             + dut_i.adv_config_reader_i.props_i.fail_count;
    endfunction

    // expected outputs after one rising edge from the inputs it sampled
    task automatic model_edge();
        case (reset_conf_out)
            LED_MODE_DC:  led_exp = dc_exp;
            LED_MODE_ADV: led_exp = ~adv7513_ready;
            default:      led_exp = opt_exp;
        endcase
        // edges seen with the request low saturate past the hold
        if (reset_dc_out)
            dc_since = 0;
        else if (dc_since <= hold_len)
            dc_since++;
        if (reset_opt_out)
            opt_since = 0;
        else if (reset_dc_out)
            opt_since = hold_len + 1;
        else if (opt_since <= hold_len)
            opt_since++;
        dc_exp  = (dc_since > hold_len);
        opt_exp = (opt_since > hold_len);
        // three input bits per edge with the newest at the bottom
        lk_hist   = reset_dc_out ? '0
                  : {lk_hist[8:0], fullcycle, pll_hdmi_locked, pll54_locked};
        loss_exp  = lk_hist[10:9] & ~lk_hist[7:6];
        ready_exp = lk_hist[4] & lk_hist[5];
        if (reset_dc_out)
            start_cnt = 0;
        else if (start_cnt < startup_len)
            start_cnt++;
        start_exp = (start_cnt >= startup_len);
        // word goes out the edge after its fourth byte is taken
        upd_exp = done_m && !reset_dc_out;
        if (reset_dc_out)
            cfg_exp = '0;
        else if (done_m)
            cfg_exp = word_m;
        frames_seen += upd_exp;
        done_m = 1'b0;
        if (pend_m) begin
            // byte n of a frame sits n bytes below the top
            word_m[(ADV_FRAME_BYTES - 1 - nbytes) * ADV_BYTE_W +: ADV_BYTE_W] = pend_byte;
            nbytes = (nbytes + 1) % ADV_FRAME_BYTES;
            done_m = (nbytes == 0);
        end
        if (reset_dc_out) begin
            nbytes = 0;
            done_m = 1'b0;
        end
        pend_m   = rdreq_prev && !reset_dc_out;
        rden_exp = !reset_dc_out;
    endtask

    // FIFO request checked before the edge and outputs after it
    task automatic cycle();
        int unsigned burst;
        @(negedge control_clock);
        rdreq_prev = fifo_rdreq;
        check_level("fifo_rdreq", fifo_rdreq, rden_exp & ~fifo_rdempty);
        @(posedge control_clock);
        #1;
        model_edge();
        check_level("dc_nreset", dc_nreset, dc_exp);
        check_level("opt_nreset", opt_nreset, opt_exp);
        check_level("status_led_nreset", status_led_nreset, led_exp);
        check_level("output_ready", output_ready, ready_exp);
        check_level("adv_start", adv_start, start_exp);
        check_pulse("pll54_lockloss", pll54_lockloss, loss_exp[0]);
        check_pulse("pll_hdmi_lockloss", pll_hdmi_lockloss, loss_exp[1]);
        check_pulse("cfg_update", cfg_update, upd_exp);
        check_config(adv_config, cfg_exp);
        if (property_failures() != 0)
            fail_now("a bound assertion on the reset stretchers or the reader failed");
        // popped byte sits on fifo_q through the next cycle
        if (rdreq_prev) begin
            pend_byte = fifo_mem.pop_front();
            fifo_q    = pend_byte;
        end
        if (push_on && $urandom_range(0, 3) == 0) begin
            burst = $urandom_range(1, 6);
            while (burst > 0 && pushed < frame_total * ADV_FRAME_BYTES) begin
                fifo_mem.push_back(ADV_BYTE_W'($urandom_range(0, 255)));
                pushed++;
                burst--;
            end
        end
        fifo_rdempty = (fifo_mem.size() == 0);
        if ($urandom_range(0, 11) == 0)
            pll54_locked = ~pll54_locked;
        if ($urandom_range(0, 11) == 0)
            pll_hdmi_locked = ~pll_hdmi_locked;
        if ($urandom_range(0, 11) == 0)
            fullcycle = ~fullcycle;
    endtask

    initial begin
        int unsigned edges;
        void'($urandom(34267));
        reset_dc_out    = 1'b1;
        reset_opt_out   = 1'b0;
        reset_conf_out  = LED_MODE_ADV;
        adv7513_ready   = 1'b0;
        pll54_locked    = 1'b0;
        pll_hdmi_locked = 1'b0;
        fullcycle       = 1'b0;
        fifo_rdempty    = 1'b1;
        fifo_q          = '0;
        repeat (2) cycle();
        reset_dc_out = 1'b0;

        // random reset pulses that may land inside the hold
        repeat (mixed_len) begin
            cycle();
            if (rst_left > 0)
                rst_left--;
            else if ($urandom_range(0, 59) == 0)
                rst_left = $urandom_range(1, 3);
            if (opt_left > 0)
                opt_left--;
            else if ($urandom_range(0, 39) == 0)
                opt_left = $urandom_range(1, 8);
            reset_dc_out  = (rst_left > 0);
            reset_opt_out = (opt_left > 0);
            if ($urandom_range(0, 9) == 0)
                reset_conf_out = RESET_CONF_W'($urandom_range(0, 5));
            if ($urandom_range(0, 7) == 0)
                adv7513_ready = ~adv7513_ready;
        end

        // configuration frames from a FIFO that runs empty at random
        reset_dc_out  = 1'b0;
        reset_opt_out = 1'b0;
        push_on       = 1'b1;
        frames_seen   = 0;
        while (frames_seen < frame_total || fifo_mem.size() != 0)
            cycle();
        if (nbytes != 0 || pushed != frame_total * ADV_FRAME_BYTES)
            fail_now("queued bytes did not all end up in configuration frames");

        // startup delay after a fresh reset
        reset_dc_out = 1'b1;
        repeat (2) cycle();
        reset_dc_out = 1'b0;
        edges = 0;
        do begin
            cycle();
            edges++;
        end while (!adv_start);
        if (edges != startup_len)
            fail_now($sformatf("adv_start rose %0d edges after reset, expected %0d",
                               edges, startup_len));

        repeat (5) cycle();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
design/reset_pkg.sv
design/adv_pkg.sv
design/reset_stretch.sv
design/reset_manager.sv
design/lock_monitor.sv
design/startup_delay.sv
design/adv_config_reader.sv
design/control_domain_top.sv
dv/control_domain_props.sv
dv/control_domain_tb.sv

//--- Bender.yml
package:
  name: control_domain

sources:
  - design/reset_pkg.sv
  - design/adv_pkg.sv
  - design/reset_stretch.sv
  - design/reset_manager.sv
  - design/lock_monitor.sv
  - design/startup_delay.sv
  - design/adv_config_reader.sv
  - design/control_domain_top.sv
  - target: test
    files:
      - dv/control_domain_props.sv
      - dv/control_domain_tb.sv
